/* common/video_pkg.sv */
package video_pkg;

	// raster size, one line of 448 pixels and 320 lines per frame
	localparam logic [8:0] h_total = 9'd448;
	localparam logic [8:0] v_total = 9'd320;

	// horizontal sync pulse, pixels
	localparam logic [8:0] hs_beg = 9'd8;
	localparam logic [8:0] hs_end = 9'd40;

	// vertical sync pulse, lines
	localparam logic [8:0] vs_beg = 9'd0;
	localparam logic [8:0] vs_end = 9'd2;

	// first unblanked pixel and line
	localparam logic [8:0] hblank_end = 9'd72;
	localparam logic [8:0] vblank_end = 9'd16;

	// 256 x 192 bitmap window
	localparam logic [8:0] hpix_beg = 9'd96;
	localparam logic [8:0] hpix_end = 9'd352;
	localparam logic [8:0] vpix_beg = 9'd64;
	localparam logic [8:0] vpix_end = 9'd256;

	// configuration as seen by sync and render
	typedef struct packed {
		logic [7:0] border;
		logic [7:0] vpage;
		logic [3:0] palsel;
		// interrupt column, counted in pixel pairs
		logic [7:0] hint_beg;
		logic [8:0] vint_beg;
	} video_regs_t;

	// timing of the pixel position the counters hold
	typedef struct packed {
		logic [8:0] hcnt;
		logic [8:0] vcnt;
		logic       blank;
		// inside the bitmap window
		logic       hvpix;
		logic       frame_start;
	} video_timing_t;

	// palette entry
	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb555_t;

	// pixel index, a cram address or a palette/ink pair
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [3:0] pal;
			logic [3:0] ink;
		} f;
	} video_plex_u;

endpackage

/* source/video_ports.sv */
module video_ports (
	input  logic                  clk,
	input  logic                  arst_n,

	// z80 port data and write strobes
	input  logic [7:0]            d,
	input  logic                  border_wr,
	input  logic                  vpage_wr,
	input  logic                  palsel_wr,
	input  logic                  hint_beg_wr,
	input  logic                  vint_begl_wr,
	input  logic                  vint_begh_wr,

	input  logic                  frame_start,
	output video_pkg::video_regs_t regs
);

	// values written by the cpu, not yet visible
	video_pkg::video_regs_t shadow;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			shadow <= '0;
		end else begin
			if (border_wr) begin
				shadow.border <= d;
			end
			if (vpage_wr) begin
				shadow.vpage <= d;
			end
			// only the low nibble selects the pixel palette
			if (palsel_wr) begin
				shadow.palsel <= d[3:0];
			end
			if (hint_beg_wr) begin
				shadow.hint_beg <= d;
			end
			if (vint_begl_wr) begin
				shadow.vint_beg[7:0] <= d;
			end
			// bit 8 of the interrupt line
			if (vint_begh_wr) begin
				shadow.vint_beg[8] <= d[0];
			end
		end
	end

	// whole set moves at frame start so a frame never mixes two setups
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '0;
		end else if (frame_start) begin
			regs <= shadow;
		end
	end

endmodule

/* video_sync/video_sync.sv */
module video_sync (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     c3,
	input  video_pkg::video_regs_t   regs,

	output video_pkg::video_timing_t timing,
	output logic                     hsync,
	output logic                     vsync,
	output logic                     csync,
	output logic                     int_start
);

	logic [8:0] hcnt;
	logic [8:0] vcnt;
	logic       line_end;
	logic       hs_lvl;
	logic       vs_lvl;
	logic       int_pos;

	assign line_end = (hcnt == video_pkg::h_total - 9'd1);

	// raster counters, one step per pixel strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (c3) begin
			if (line_end) begin
				hcnt <= '0;
				if (vcnt == video_pkg::v_total - 9'd1) begin
					vcnt <= '0;
				end else begin
					vcnt <= vcnt + 9'd1;
				end
			end else begin
				hcnt <= hcnt + 9'd1;
			end
		end
	end

	// sync levels for the current position
	assign hs_lvl = (hcnt >= video_pkg::hs_beg) && (hcnt < video_pkg::hs_end);
	assign vs_lvl = (vcnt >= video_pkg::vs_beg) && (vcnt < video_pkg::vs_end);

	// outputs follow the counters one clock later
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b0;
		end else begin
			hsync <= hs_lvl;
			vsync <= vs_lvl;
			csync <= hs_lvl ^ vs_lvl;
		end
	end

	// interrupt column is given in pixel pairs
	assign int_pos = (hcnt == {regs.hint_beg, 1'b0}) && (vcnt == regs.vint_beg);

	// the pulse is taken on the strobe that leaves the position,
	// so a slow c3 still gives a single clock
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			int_start <= 1'b0;
		end else begin
			int_start <= c3 && int_pos;
		end
	end

	assign timing.hcnt  = hcnt;
	assign timing.vcnt  = vcnt;
	assign timing.blank = (hcnt < video_pkg::hblank_end) || (vcnt < video_pkg::vblank_end);

	// bitmap window
	assign timing.hvpix = (hcnt >= video_pkg::hpix_beg) && (hcnt < video_pkg::hpix_end) &&
		(vcnt >= video_pkg::vpix_beg) && (vcnt < video_pkg::vpix_end);

	assign timing.frame_start = (hcnt == 9'd0) && (vcnt == 9'd0);

endmodule

/* video_render/video_render.sv */
module video_render (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     c3,
	input  video_pkg::video_regs_t   regs,
	input  video_pkg::video_timing_t timing,

	// dram read port
	input  logic [15:0]              dram_rddata,
	input  logic                     video_strobe,
	output logic [20:0]              video_addr,
	output logic                     video_go,

	output video_pkg::video_plex_u   plex,
	output logic                     blank_d
);

	logic [8:0]  line_rel;
	logic [8:0]  col_rel;
	logic        vline;
	logic        fetch_pos;
	logic        word_start;
	logic [15:0] next_word;
	logic [15:0] pix_sr;
	logic [3:0]  ink;

	// offsets into the bitmap, columns counted from 4 pixels before the window
	assign line_rel = timing.vcnt - video_pkg::vpix_beg;
	assign col_rel  = timing.hcnt - (video_pkg::hpix_beg - 9'd4);

	assign vline = (timing.vcnt >= video_pkg::vpix_beg) && (timing.vcnt < video_pkg::vpix_end);

	// one request per word, 4 pixels ahead of its display
	assign fetch_pos = vline && (timing.hcnt >= video_pkg::hpix_beg - 9'd4) &&
		(timing.hcnt < video_pkg::hpix_end - 9'd4) && (col_rel[1:0] == 2'b00);

	assign video_go   = c3 && fetch_pos;
	assign video_addr = {regs.vpage[5:0], line_rel[7:0], col_rel[8:2]};

	// hpix_beg is word aligned, so col_rel marks the boundaries too
	assign word_start = timing.hvpix && (col_rel[1:0] == 2'b00);

	// prefetched word, overwritten by the next answer
	always_ff @(posedge clk) begin
		if (video_strobe) begin
			next_word <= dram_rddata;
		end
	end

	// first nibble is taken straight from the prefetch register
	assign ink = word_start ? next_word[3:0] : pix_sr[3:0];

	// displayed word, shifted down one nibble per pixel
	always_ff @(posedge clk) begin
		if (c3) begin
			if (word_start) begin
				pix_sr <= {4'b0000, next_word[15:4]};
			end else begin
				pix_sr <= {4'b0000, pix_sr[15:4]};
			end
		end
	end

	// border outside the window, palette and ink inside
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			plex    <= '0;
			blank_d <= 1'b0;
		end else if (c3) begin
			if (timing.hvpix) begin
				plex.f.pal <= regs.palsel;
				plex.f.ink <= ink;
			end else begin
				plex.raw <= regs.border;
			end
			blank_d <= timing.blank;
		end
	end

endmodule

/* source/video_cram.sv */
module video_cram (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   c3,

	// z80 write side
	input  logic                   cram_we,
	input  logic [7:0]             zma,
	input  video_pkg::rgb555_t     zmd,

	input  video_pkg::video_plex_u plex,
	input  logic                   blank_d,

	// 2 bits per channel to the dac
	output logic [1:0]             vred,
	output logic [1:0]             vgrn,
	output logic [1:0]             vblu
);

	video_pkg::rgb555_t mem [0:255];
	video_pkg::rgb555_t col;

	always_ff @(posedge clk) begin
		if (cram_we) begin
			mem[zma] <= zmd;
		end
	end

	assign col = mem[plex.raw];

	// top bits of each channel, black during blanking
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vred <= 2'b00;
			vgrn <= 2'b00;
			vblu <= 2'b00;
		end else if (c3) begin
			vred <= blank_d ? 2'b00 : col.r[4:3];
			vgrn <= blank_d ? 2'b00 : col.g[4:3];
			vblu <= blank_d ? 2'b00 : col.b[4:3];
		end
	end

endmodule

/* source/video_top.sv */
module video_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               c3,

	// port writes
	input  logic [7:0]         d,
	input  logic               border_wr,
	input  logic               vpage_wr,
	input  logic               palsel_wr,
	input  logic               hint_beg_wr,
	input  logic               vint_begl_wr,
	input  logic               vint_begh_wr,

	// palette writes
	input  logic               cram_we,
	input  logic [7:0]         zma,
	input  video_pkg::rgb555_t zmd,

	// dram
	output logic [20:0]        video_addr,
	output logic               video_go,
	input  logic [15:0]        dram_rddata,
	input  logic               video_strobe,

	output logic               hsync,
	output logic               vsync,
	output logic               csync,
	output logic               int_start,
	output logic [1:0]         vred,
	output logic [1:0]         vgrn,
	output logic [1:0]         vblu
);

	video_pkg::video_regs_t   regs;
	video_pkg::video_timing_t timing;
	video_pkg::video_plex_u   plex;
	logic                     blank_d;

	video_ports video_ports_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.d            (d),
		.border_wr    (border_wr),
		.vpage_wr     (vpage_wr),
		.palsel_wr    (palsel_wr),
		.hint_beg_wr  (hint_beg_wr),
		.vint_begl_wr (vint_begl_wr),
		.vint_begh_wr (vint_begh_wr),
		.frame_start  (timing.frame_start),
		.regs         (regs)
	);

	video_sync video_sync_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.c3        (c3),
		.regs      (regs),
		.timing    (timing),
		.hsync     (hsync),
		.vsync     (vsync),
		.csync     (csync),
		.int_start (int_start)
	);

	video_render video_render_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.c3           (c3),
		.regs         (regs),
		.timing       (timing),
		.dram_rddata  (dram_rddata),
		.video_strobe (video_strobe),
		.video_addr   (video_addr),
		.video_go     (video_go),
		.plex         (plex),
		.blank_d      (blank_d)
	);

	video_cram video_cram_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.c3      (c3),
		.cram_we (cram_we),
		.zma     (zma),
		.zmd     (zmd),
		.plex    (plex),
		.blank_d (blank_d),
		.vred    (vred),
		.vgrn    (vgrn),
		.vblu    (vblu)
	);

endmodule

/* test/video_clock.sv */
module video_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

endmodule

/* test/video_assertions.sv */
module video_assertions (
	input logic       clk,
	input logic       arst_n,
	input logic       int_start,
	input logic       video_go,
	input logic       video_strobe,
	input logic       blank_d,
	input logic [1:0] vred,
	input logic [1:0] vgrn,
	input logic [1:0] vblu
);
	timeunit 1ns;
	timeprecision 100ps;

	// dram requests not answered yet
	logic [2:0] pending;
	int         failures = 0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 3'd0;
		end else begin
			pending <= pending + {2'b00, video_go} - {2'b00, video_strobe};
		end
	end

	int_single: assert property (@(posedge clk) disable iff (!arst_n)
		int_start |=> !int_start)
	else begin
		failures++;
		$error("int_start high for more than one clock");
	end

	strobe_requested: assert property (@(posedge clk) disable iff (!arst_n)
		video_strobe |-> (pending != 3'd0))
	else begin
		failures++;
		$error("video_strobe without an outstanding request");
	end

	// the word is needed at the boundary 4 pixels after the request
	answer_in_time: assert property (@(posedge clk) disable iff (!arst_n)
		video_go |-> ##[1:3] video_strobe)
	else begin
		failures++;
		$error("dram request not answered before the fourth clock");
	end

	// colour is registered one clock after blank_d
	dark_in_blank: assert property (@(posedge clk) disable iff (!arst_n)
		blank_d |=> ({vred, vgrn, vblu} == 6'd0))
	else begin
		failures++;
		$error("colour not black during blanking");
	end

endmodule

/* test/video_tb.sv */
module video_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic               clk;
	logic               arst_n;
	logic               c3;
	logic [7:0]         d;
	logic               border_wr, vpage_wr, palsel_wr;
	logic               hint_beg_wr, vint_begl_wr, vint_begh_wr;
	logic               cram_we;
	logic [7:0]         zma;
	video_pkg::rgb555_t zmd;
	logic [20:0]        video_addr;
	logic               video_go;
	logic [15:0]        dram_rddata;
	logic               video_strobe;
	logic               hsync, vsync, csync, int_start;
	logic [1:0]         vred, vgrn, vblu;

	int     line_len = int'(video_pkg::h_total);
	int     frame_len = int'(video_pkg::h_total) * int'(video_pkg::v_total);
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;
	integer seed = 32'hf18c;

	// model copy of the palette and the configuration in force
	video_pkg::rgb555_t cram_copy [0:255];
	logic [7:0]         cfg_border = 8'h00;
	logic [7:0]         cfg_vpage = 8'h00;
	logic [3:0]         cfg_palsel = 4'h0;
	int                 int_col;
	int                 int_line;

	video_clock video_clock_inst (.clk(clk));

	video_top video_top_inst (.*);

	bind video_top video_assertions video_assertions_inst (.*);

	// dram answers each request on the next clock
	always @(posedge clk) begin
		video_strobe <= video_go;
		if (video_go)
			dram_rddata <= video_addr[15:0] ^ 16'h5a3c;
	end

	// eight frames cover all tests
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= 8 * frame_len) begin
			$display("timeout: run stopped after %0d clocks", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic test_done(input string name, input int err0);
		$display("test %s finished with %0d errors", name, errors - err0);
	endtask

	// one strobe per bit, border first and vint_begh last
	task automatic port_write(input logic [5:0] strobes, input logic [7:0] value);
		@(posedge clk);
		d <= value;
		{border_wr, vpage_wr, palsel_wr, hint_beg_wr, vint_begl_wr, vint_begh_wr} <= strobes;
		@(posedge clk);
		{border_wr, vpage_wr, palsel_wr, hint_beg_wr, vint_begl_wr, vint_begh_wr} <= 6'b0;
	endtask

	task automatic wait_vsync_rise;
		logic prev;
		prev = vsync;
		for (int n = 0; n < 2 * frame_len; n++) begin
			@(negedge clk);
			if (vsync && !prev)
				return;
			prev = vsync;
		end
		report_error("vsync did not rise within two frames");
	endtask

	task automatic wait_int(output int t);
		for (int n = 0; n < 2 * frame_len; n++) begin
			@(negedge clk);
			if (int_start) begin
				t = cycles;
				return;
			end
		end
		t = cycles;
		report_error("int_start did not pulse within two frames");
	endtask

	// colour for a raster position, from the border, the bitmap rule and the palette copy
	function automatic logic [5:0] expected_colour(input int pos);
		int                 h;
		int                 v;
		logic [20:0]        addr;
		logic [15:0]        word;
		logic [7:0]         idx;
		video_pkg::rgb555_t c;
		h = pos % line_len;
		v = pos / line_len;
		if (h < video_pkg::hblank_end || v < video_pkg::vblank_end)
			return 6'd0;
		idx = cfg_border;
		if (h >= video_pkg::hpix_beg && h < video_pkg::hpix_end &&
			v >= video_pkg::vpix_beg && v < video_pkg::vpix_end) begin
			addr = {cfg_vpage[5:0], 8'(v - video_pkg::vpix_beg), 7'((h - video_pkg::hpix_beg) / 4)};
			word = addr[15:0] ^ 16'h5a3c;
			idx = {cfg_palsel, 4'(word >> (4 * ((h - video_pkg::hpix_beg) % 4)))};
		end
		c = cram_copy[idx];
		return {c.r[4:3], c.g[4:3], c.b[4:3]};
	endfunction

	task automatic outputs_low;
		check_value("hsync", 0, hsync);
		check_value("vsync", 0, vsync);
		check_value("csync", 0, csync);
		check_value("int_start", 0, int_start);
		check_value("video_go", 0, video_go);
		check_value("{vred,vgrn,vblu}", 0, {vred, vgrn, vblu});
	endtask

	task automatic reset_state;
		int err0;
		err0 = errors;
		repeat (8) begin
			@(negedge clk);
			outputs_low();
		end
		@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		outputs_low();
		test_done("reset_state", err0);
	endtask

	task automatic sync_timing;
		int   err0;
		int   h_rise;
		int   v_rise;
		int   v_count;
		logic hs_prev;
		logic vs_prev;
		err0 = errors;
		h_rise = -1;
		v_rise = -1;
		v_count = 0;
		hs_prev = hsync;
		vs_prev = vsync;
		for (int n = 1; n <= 2 * frame_len && v_count < 2; n++) begin
			@(negedge clk);
			check_value("csync", hsync ^ vsync, csync);
			if (hsync && !hs_prev) begin
				if (h_rise >= 0)
					check_value("hsync period", line_len, n - h_rise);
				h_rise = n;
			end
			if (!hsync && hs_prev)
				check_value("hsync width", video_pkg::hs_end - video_pkg::hs_beg, n - h_rise);
			if (vsync && !vs_prev) begin
				if (v_rise >= 0)
					check_value("vsync period", frame_len, n - v_rise);
				v_rise = n;
				v_count++;
			end
			if (!vsync && vs_prev)
				check_value("vsync width", (video_pkg::vs_end - video_pkg::vs_beg) * line_len,
					n - v_rise);
			hs_prev = hsync;
			vs_prev = vsync;
		end
		if (v_count < 2)
			report_error("vsync did not rise twice within two frames");
		test_done("sync_timing", err0);
	endtask

	task automatic interrupt_position;
		int err0;
		int v2;
		int t0;
		int t1;
		int t2;
		int t3;
		err0 = errors;
		int_col = $unsigned($random(seed)) % 224;
		int_line = 16 + $unsigned($random(seed)) % 240;
		v2 = 16 + $unsigned($random(seed)) % 240;
		port_write(6'b000100, 8'(int_col));
		port_write(6'b000010, 8'(int_line));
		port_write(6'b000001, 8'(int_line >> 8));
		wait_vsync_rise();
		t0 = cycles;
		wait_int(t1);
		// both pulses lag their position by one clock
		check_value("int_start position", int_line * line_len + 2 * int_col, t1 - t0);
		wait_int(t2);
		check_value("int_start period", frame_len, t2 - t1);
		port_write(6'b000010, 8'(v2));
		port_write(6'b000001, 8'(v2 >> 8));
		wait_int(t3);
		check_value("int_start shifted period", frame_len + (v2 - int_line) * line_len, t3 - t2);
		int_line = v2;
		test_done("interrupt_position", err0);
	endtask

	task automatic border_colour;
		int                 err0;
		int                 t;
		int                 anchor;
		video_pkg::rgb555_t c;
		err0 = errors;
		for (int k = 0; k < 256; k++) begin
			c = 15'($random(seed));
			cram_copy[k] = c;
			@(posedge clk);
			cram_we <= 1'b1;
			zma <= 8'(k);
			zmd <= c;
		end
		@(posedge clk);
		cram_we <= 1'b0;
		cfg_border = 8'($random(seed));
		port_write(6'b100000, cfg_border);
		wait_vsync_rise();
		wait_int(t);
		// colour is 2 clocks behind the counters, int_start 1
		anchor = int_line * line_len + 2 * int_col - 1;
		for (int k = 0; k < 2 * line_len; k++) begin
			if (k > 0)
				@(negedge clk);
			check_value("{vred,vgrn,vblu}", expected_colour((anchor + k) % frame_len),
				{vred, vgrn, vblu});
		end
		test_done("border_colour", err0);
	endtask

	task automatic active_pixels;
		int   err0;
		int   h;
		int   v;
		int   fetch_beg;
		logic go;
		err0 = errors;
		fetch_beg = int'(video_pkg::hpix_beg) - 4;
		cfg_vpage = 8'($random(seed));
		cfg_palsel = 4'($random(seed));
		port_write(6'b010000, cfg_vpage);
		port_write(6'b001000, {4'h0, cfg_palsel});
		// last pixel of the previous frame is out at the vsync edge
		wait_vsync_rise();
		for (int pos = 0; pos < int'(video_pkg::vpix_end) * line_len; pos++) begin
			@(negedge clk);
			check_value("{vred,vgrn,vblu}", expected_colour(pos), {vred, vgrn, vblu});
			// the counters run 2 clocks ahead of the colour
			h = (pos + 2) % line_len;
			v = (pos + 2) / line_len;
			// one request per word, 4 pixels before the word is shown
			go = v >= video_pkg::vpix_beg && v < video_pkg::vpix_end && h >= fetch_beg &&
				h < int'(video_pkg::hpix_end) - 4 && (h - fetch_beg) % 4 == 0;
			check_value("video_go", go, video_go);
			if (go)
				check_value("video_addr", {cfg_vpage[5:0], 8'(v - video_pkg::vpix_beg),
					7'((h - fetch_beg) / 4)}, video_addr);
		end
		test_done("active_pixels", err0);
	endtask

	initial begin
		arst_n = 1'b0;
		c3 = 1'b1;
		d = 8'h00;
		{border_wr, vpage_wr, palsel_wr, hint_beg_wr, vint_begl_wr, vint_begh_wr} = 6'b0;
		cram_we = 1'b0;
		zma = 8'h00;
		zmd = '0;
		video_strobe = 1'b0;
		dram_rddata = 16'h0000;
		reset_state();
		sync_timing();
		interrupt_position();
		border_colour();
		active_pixels();
		errors = errors + video_top_inst.video_assertions_inst.failures;
		$display("5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
common/video_pkg.sv
source/video_ports.sv
video_sync/video_sync.sv
video_render/video_render.sv
source/video_cram.sv
source/video_top.sv
test/video_clock.sv
test/video_assertions.sv
test/video_tb.sv
